// ==== verilog/ethMiiPkg.sv ====
package ethMiiPkg;

  // Nibble values seen on MRxD ahead of the frame data
  localparam logic [3:0] PreambleNibble = 4'h5;
  localparam logic [3:0] SfdNibble      = 4'hd;

  // CRC-32 generator polynomial, MSB-first register form
  localparam logic [31:0] CrcPoly    = 32'h04c11db7;
  localparam logic [31:0] CrcPreset  = 32'hffffffff;
  localparam logic [31:0] CrcResidue = 32'hc704dd7b;  // Register value after a good FCS

  // Inter-frame gap, in MRxClk cycles
  localparam int          IfgCntWidth = 5;
  localparam logic [IfgCntWidth-1:0] IfgCycles = 5'd24;

  // Byte counter and maximum frame length
  localparam int ByteCntWidth = 16;

endpackage

// ==== verilog/ethBufPkg.sv ====
package ethBufPkg;
  import ethMiiPkg::*;

  // One data byte as stored in the data FIFO
  typedef struct packed {
    logic [7:0] Data;
    logic       Last;      // Final byte of the frame
  } rxDataWord;

  // One word per frame in the status FIFO
  typedef struct packed {
    logic [ByteCntWidth-1:0] Length;  // Bytes written, FCS included
    logic                    CrcErr;
    logic                    TooLong; // Cut at MaxFL
  } rxStatusWord;

  localparam int DataFifoDepth   = 2048;
  localparam int StatusFifoDepth = 8;

endpackage

// ==== verilog/ethRxStateM.sv ====
module ethRxStateM import ethMiiPkg::*;
(
  input  logic       MRxClk,
  input  logic       Reset,
  input  logic       MRxDV,
  input  logic [3:0] MRxD,
  input  logic       IfgCounterEq24,
  input  logic       ByteCntMaxFrame,
  output logic       StateIdle,
  output logic       StatePreamble,
  output logic       StateSfd,
  output logic [1:0] StateData,
  output logic       StateDrop,
  output logic       SfdSeen,
  output logic       FrameEnd
);

  typedef enum logic [2:0] {sIdle, sPreamble, sSfd, sData0, sData1, sDrop} rxStateT;

  rxStateT state;
  rxStateT nextState;

  always_comb
  begin
    nextState = state;
    case (state)
      sIdle:
        if (MRxDV)
          nextState = (MRxD == PreambleNibble) ? sPreamble : sDrop;
      sPreamble:
        if (!MRxDV)
          nextState = sIdle;
        else
          nextState = (MRxD == PreambleNibble) ? sSfd : sDrop;
      sSfd:
        if (!MRxDV)
          nextState = sIdle;
        else if (MRxD == SfdNibble)
          nextState = IfgCounterEq24 ? sData0 : sDrop;  // Gap too short drops the frame
        else if (MRxD != PreambleNibble)
          nextState = sDrop;
      sData0:
        if (!MRxDV)
          nextState = sIdle;
        else if (ByteCntMaxFrame)
          nextState = sDrop;                            // Rest of a long frame is ignored
        else
          nextState = sData1;
      sData1:
        nextState = MRxDV ? sData0 : sIdle;
      sDrop:
        if (!MRxDV)
          nextState = sIdle;
      default:
        nextState = sIdle;
    endcase
  end

  always_ff @(posedge MRxClk or posedge Reset)
  begin
    if (Reset)
      state <= sIdle;
    else
      state <= nextState;
  end

  assign StateIdle     = state == sIdle;
  assign StatePreamble = state == sPreamble;
  assign StateSfd      = state == sSfd;
  assign StateData     = {state == sData1, state == sData0};  // Low nibble in bit 0
  assign StateDrop     = state == sDrop;

  assign SfdSeen  = StateSfd & MRxDV & (MRxD == SfdNibble);
  assign FrameEnd = StateData[0] & (~MRxDV | ByteCntMaxFrame) | StateData[1] & ~MRxDV;

endmodule

// ==== verilog/ethRxCounters.sv ====
module ethRxCounters import ethMiiPkg::*;
(
  input  logic                    MRxClk,
  input  logic                    Reset,
  input  logic                    SfdSeen,
  input  logic                    StateIdle,
  input  logic                    StatePreamble,
  input  logic                    StateSfd,
  input  logic [1:0]              StateData,
  input  logic                    StateDrop,
  input  logic [ByteCntWidth-1:0] MaxFL,
  input  logic                    HugEn,
  input  logic                    IgnoreIfg,
  output logic [ByteCntWidth-1:0] ByteCnt,
  output logic                    ByteCntMaxFrame,
  output logic                    IfgCounterEq24
);

  logic [IfgCntWidth-1:0] ifgCnt;
  logic                   byteCntMax;
  logic                   byteCntInc;
  logic                   ifgDone;
  logic                   ifgInc;

  assign byteCntMax = &ByteCnt;                    // Saturation point
  assign byteCntInc = StateData[1] & ~byteCntMax;  // One per high nibble

  always_ff @(posedge MRxClk or posedge Reset)
  begin
    if (Reset)
    begin
      ByteCnt <= '0;
    end
    else
    begin
      if (SfdSeen)
        ByteCnt <= '0;
      else if (byteCntInc)
        ByteCnt <= ByteCnt + 1'b1;
    end
  end

  // Compared only at a byte boundary, where the count has just settled
  assign ByteCntMaxFrame = StateData[0] & (ByteCnt == MaxFL) & ~HugEn;

  // Gap runs outside the data states and stops at the limit
  assign ifgDone = ifgCnt == IfgCycles;
  assign ifgInc  = (StateIdle | StatePreamble | StateSfd | StateDrop) & ~ifgDone;

  always_ff @(posedge MRxClk or posedge Reset)
  begin
    if (Reset)
    begin
      ifgCnt <= '0;
    end
    else
    begin
      if (SfdSeen)
        ifgCnt <= '0;
      else if (ifgInc)
        ifgCnt <= ifgCnt + 1'b1;
    end
  end

  assign IfgCounterEq24 = ifgDone | IgnoreIfg;  // IgnoreIfg accepts any gap

endmodule

// ==== verilog/ethRxCrc.sv ====
module ethRxCrc import ethMiiPkg::*;
(
  input  logic       MRxClk,
  input  logic       Reset,
  input  logic [3:0] MRxD,
  input  logic       SfdSeen,
  input  logic [1:0] StateData,
  output logic       CrcErr
);

  logic [31:0] crc;

  // Four serial steps, MRxD[0] first as it left the wire
  function automatic logic [31:0] crcNibble(input logic [31:0] crcIn, input logic [3:0] nibble);
    logic [31:0] c;
    c = crcIn;
    for (int i = 0; i < 4; i++)
    begin
      if (c[31] ^ nibble[i])
        c = {c[30:0], 1'b0} ^ CrcPoly;
      else
        c = {c[30:0], 1'b0};
    end
    return c;
  endfunction

  always_ff @(posedge MRxClk or posedge Reset)
  begin
    if (Reset)
      crc <= CrcPreset;
    else if (SfdSeen)
      crc <= CrcPreset;                 // Fresh start for every frame
    else if (|StateData)
      crc <= crcNibble(crc, MRxD);
  end

  // FCS is part of the sum, so a good frame leaves the fixed residue
  assign CrcErr = crc != CrcResidue;

endmodule

// ==== verilog/ethRxByteAssembler.sv ====
module ethRxByteAssembler import ethMiiPkg::*, ethBufPkg::*;
(
  input  logic                    MRxClk,
  input  logic                    Reset,
  input  logic [3:0]              MRxD,
  input  logic [1:0]              StateData,
  input  logic                    FrameEnd,
  input  logic                    ByteCntMaxFrame,
  input  logic [ByteCntWidth-1:0] ByteCnt,
  input  logic                    CrcErr,
  output logic                    DataWrite,
  output rxDataWord               DataWord,
  output logic                    StatusWrite,
  output rxStatusWord             StatusWord
);

  logic [3:0] lowNibble;
  logic [7:0] heldByte;
  logic       heldValid;   // heldByte waits for its Last decision

  always_ff @(posedge MRxClk or posedge Reset)
  begin
    if (Reset)
    begin
      heldValid   <= 1'b0;
      DataWrite   <= 1'b0;
      StatusWrite <= 1'b0;
    end
    else
    begin
      DataWrite   <= heldValid & (FrameEnd | StateData[1]);
      StatusWrite <= heldValid & FrameEnd;    // Same cycle as the Last byte
      if (FrameEnd)
        heldValid <= 1'b0;
      else if (StateData[1])
        heldValid <= 1'b1;
    end
  end

  always_ff @(posedge MRxClk)
  begin
    if (StateData[0])
      lowNibble <= MRxD;
    if (StateData[1] && !FrameEnd)
      heldByte <= {MRxD, lowNibble};          // High nibble completes the byte
    DataWord.Data      <= heldByte;
    DataWord.Last      <= FrameEnd;
    StatusWord.Length  <= ByteCnt;
    StatusWord.CrcErr  <= CrcErr;
    StatusWord.TooLong <= ByteCntMaxFrame;
  end

endmodule

// ==== verilog/ethRxFifo.sv ====
module ethRxFifo #(
  parameter type WordType = logic [7:0],
  parameter int  Depth    = 16            // Power of two
)
(
  input  logic    MRxClk,
  input  logic    Reset,
  input  logic    Write,
  input  WordType WriteWord,
  input  logic    Read,
  output WordType ReadWord,
  output logic    Empty
);

  // One extra pointer bit tells a full buffer from an empty one
  logic [$clog2(Depth):0] wrPtr;
  logic [$clog2(Depth):0] rdPtr;

  WordType mem [Depth];

  always_ff @(posedge MRxClk or posedge Reset)
  begin
    if (Reset)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
    end
    else
    begin
      if (Write)
        wrPtr <= wrPtr + 1'b1;
      if (Read)
        rdPtr <= rdPtr + 1'b1;
    end
  end

  always_ff @(posedge MRxClk)
  begin
    if (Write)
      mem[wrPtr[$clog2(Depth)-1:0]] <= WriteWord;
  end

  // Head word is always on the output
  assign ReadWord = mem[rdPtr[$clog2(Depth)-1:0]];
  assign Empty    = wrPtr == rdPtr;

endmodule

// ==== verilog/ethRxHostReader.sv ====
module ethRxHostReader import ethMiiPkg::*, ethBufPkg::*;
(
  input  logic                    MRxClk,
  input  logic                    Reset,
  input  rxDataWord               DataReadWord,
  input  logic                    DataEmpty,
  input  rxStatusWord             StatusReadWord,
  input  logic                    StatusEmpty,
  input  logic                    HostStall,
  output logic                    DataRead,
  output logic                    StatusRead,
  output logic [7:0]              HostData,
  output logic                    HostValid,
  output logic                    HostFirst,
  output logic                    HostLast,
  output logic [ByteCntWidth-1:0] HostLength,
  output logic                    HostCrcErr,
  output logic                    HostTooLong
);

  logic inFrame;        // Status taken, bytes still to move
  logic firstPending;

  // Nothing moves while the host stalls, so every output holds
  assign StatusRead = ~inFrame & ~StatusEmpty & ~HostStall;
  assign DataRead   = inFrame & ~DataEmpty & ~HostStall;

  always_ff @(posedge MRxClk or posedge Reset)
  begin
    if (Reset)
    begin
      inFrame      <= 1'b0;
      firstPending <= 1'b0;
      HostValid    <= 1'b0;
    end
    else if (!HostStall)
    begin
      HostValid <= DataRead;
      if (StatusRead)
      begin
        inFrame      <= 1'b1;
        firstPending <= 1'b1;
      end
      else if (DataRead)
      begin
        firstPending <= 1'b0;
        if (DataReadWord.Last)
          inFrame <= 1'b0;     // Back to idle after the Last byte
      end
    end
  end

  always_ff @(posedge MRxClk)
  begin
    if (DataRead)
    begin
      HostData  <= DataReadWord.Data;
      HostFirst <= firstPending;
      HostLast  <= DataReadWord.Last;
    end
    if (StatusRead)
    begin
      HostLength  <= StatusReadWord.Length;   // Held for the whole frame
      HostCrcErr  <= StatusReadWord.CrcErr;
      HostTooLong <= StatusReadWord.TooLong;
    end
  end

endmodule

// ==== verilog/ethRx.sv ====
module ethRx import ethMiiPkg::*, ethBufPkg::*;
(
  input  logic                    MRxClk,
  input  logic                    Reset,
  input  logic                    MRxDV,
  input  logic [3:0]              MRxD,
  input  logic [ByteCntWidth-1:0] MaxFL,
  input  logic                    HugEn,
  input  logic                    IgnoreIfg,
  input  logic                    HostStall,
  output logic [7:0]              HostData,
  output logic                    HostValid,
  output logic                    HostFirst,
  output logic                    HostLast,
  output logic [ByteCntWidth-1:0] HostLength,
  output logic                    HostCrcErr,
  output logic                    HostTooLong
);

  logic                    StateIdle;
  logic                    StatePreamble;
  logic                    StateSfd;
  logic [1:0]              StateData;
  logic                    StateDrop;
  logic                    SfdSeen;
  logic                    FrameEnd;
  logic                    IfgCounterEq24;
  logic                    ByteCntMaxFrame;
  logic [ByteCntWidth-1:0] ByteCnt;
  logic                    CrcErr;
  logic                    DataWrite;
  logic                    StatusWrite;
  logic                    DataRead;
  logic                    StatusRead;
  logic                    DataEmpty;
  logic                    StatusEmpty;
  rxDataWord               DataWord;
  rxDataWord               DataReadWord;
  rxStatusWord             StatusWord;
  rxStatusWord             StatusReadWord;

  // Producer side
  ethRxStateM        stateM        (.*);
  ethRxCounters      counters      (.*);
  ethRxCrc           crc           (.*);
  ethRxByteAssembler byteAssembler (.*);

  ethRxFifo #(.WordType(rxDataWord), .Depth(DataFifoDepth)) dataFifo (
    .MRxClk    (MRxClk),
    .Reset     (Reset),
    .Write     (DataWrite),
    .WriteWord (DataWord),
    .Read      (DataRead),
    .ReadWord  (DataReadWord),
    .Empty     (DataEmpty)
  );

  ethRxFifo #(.WordType(rxStatusWord), .Depth(StatusFifoDepth)) statusFifo (
    .MRxClk    (MRxClk),
    .Reset     (Reset),
    .Write     (StatusWrite),
    .WriteWord (StatusWord),
    .Read      (StatusRead),
    .ReadWord  (StatusReadWord),
    .Empty     (StatusEmpty)
  );

  // Host side
  ethRxHostReader hostReader (.*);

endmodule

// ==== testbench/ethRxTb.sv ====
module ethRxTb import ethMiiPkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NumFrames = 40;
  localparam int MaxLen    = 200;

  logic                    MRxClk = 1'b0;
  logic                    Reset;
  logic                    MRxDV;
  logic [3:0]              MRxD;
  logic [ByteCntWidth-1:0] MaxFL;
  logic                    HugEn;
  logic                    IgnoreIfg;
  logic                    HostStall;
  logic [7:0]              HostData;
  logic                    HostValid;
  logic                    HostFirst;
  logic                    HostLast;
  logic [ByteCntWidth-1:0] HostLength;
  logic                    HostCrcErr;
  logic                    HostTooLong;

  logic [7:0] frameBytes [NumFrames][MaxLen];
  int         frameLen   [NumFrames];
  int         gapLen     [NumFrames];   // Idle cycles ahead of the frame
  int         outLen     [NumFrames];   // Bytes the host should see
  bit         accepted   [NumFrames];
  bit         tooLong    [NumFrames];
  bit         crcBad     [NumFrames];

  // Reference model queues filled as each SFD goes out
  logic [7:0]              expByteQ [$];
  logic [ByteCntWidth-1:0] expLenQ  [$];
  bit                      expCrcQ  [$];
  bit                      expLongQ [$];

  int          errors      = 0;
  int          framesDone  = 0;
  int          framesSent  = 0;
  int          byteIdx     = 0;
  int          watchCycles = 0;
  bit          monitorOn   = 1'b0;
  bit          firstDone   = 1'b0;
  bit          prevStall   = 1'b0;
  bit          nextStall;
  logic [28:0] holdOut;                 // Host outputs seen at the last falling edge

  ethRx dut_i (.*);

  always #20 MRxClk = ~MRxClk;

  // Frames 12 to 25 run with MaxFL 100 and 20 to 25 also with HugEn; 26 to 33 ignore the gap
  function automatic logic [ByteCntWidth-1:0] maxFlFor(input int f);
    return (f >= 12 && f < 26) ? 16'd100 : 16'd1536;
  endfunction

  function automatic bit hugEnFor(input int f);
    return f >= 20 && f < 26;
  endfunction

  function automatic bit ignoreIfgFor(input int f);
    return f >= 26 && f < 34;
  endfunction

  // Ethernet CRC-32 over the first n bytes with bit 0 of each byte first
  function automatic logic [31:0] crcOfPrefix(input int f, input int n);
    logic [31:0] r;
    logic        fb;
    r = 32'hffffffff;
    for (int k = 0; k < n; k++)
      for (int i = 0; i < 8; i++)
      begin
        fb = r[31] ^ frameBytes[f][k][i];
        r  = {r[30:0], 1'b0} ^ (fb ? CrcPoly : 32'h0);
      end
    return r;
  endfunction

  function automatic logic [28:0] hostSnapshot();
    return {HostValid, HostFirst, HostLast, HostCrcErr, HostTooLong, HostData, HostLength};
  endfunction

  task automatic reportMismatch(input string name, input logic [31:0] expVal,
                                input logic [31:0] actVal);
    $display("Error at %0d ns: %s expected 0x%0h, got 0x%0h", $time, name, expVal, actVal);
    errors++;
  endtask

  task automatic planFrames();
    logic [31:0] crc;
    bit          prevClean;
    bit          shortGap;
    int          len;
    int          total;
    int          pos;
    prevClean = 1'b0;
    total     = 0;
    for (int f = 0; f < NumFrames; f++)
    begin
      len         = $urandom_range(MaxLen, 20);
      frameLen[f] = len;
      for (int b = 0; b < len - 4; b++)
        frameBytes[f][b] = 8'($urandom_range(255));
      crc = crcOfPrefix(f, len - 4);
      for (int j = 0; j < 4; j++)        // Inverted register with bit 31 first on the wire
        for (int i = 0; i < 8; i++)
          frameBytes[f][len-4+j][i] = ~crc[31-8*j-i];
      crcBad[f] = $urandom_range(3) == 0;
      if (crcBad[f])
      begin
        pos                = len - 1 - int'($urandom_range(3));
        frameBytes[f][pos] = frameBytes[f][pos] ^ 8'($urandom_range(255, 1));
      end
      // A clean frame leaves the gap counter at zero, so 2 idle cycles fall short
      shortGap    = prevClean && (ignoreIfgFor(f) || $urandom_range(2) == 0);
      gapLen[f]   = shortGap ? 2 : $urandom_range(30, 12);
      accepted[f] = !shortGap || ignoreIfgFor(f);
      tooLong[f]  = accepted[f] && !hugEnFor(f) && len >= maxFlFor(f);
      outLen[f]   = tooLong[f] ? int'(maxFlFor(f)) : len;
      if (tooLong[f])
        crcBad[f] = crcOfPrefix(f, outLen[f]) != CrcResidue;  // Sum stops at the cut
      prevClean   = accepted[f] && !tooLong[f];
      total      += gapLen[f] + 16 + 2 * len;
    end
    watchCycles = 2 * total + 2000;
  endtask

  task automatic driveNibble(input logic dv, input logic [3:0] nibble);
    @(negedge MRxClk);
    MRxDV = dv;
    MRxD  = nibble;
  endtask

  task automatic queueFrame(input int f);
    for (int b = 0; b < outLen[f]; b++)
      expByteQ.push_back(frameBytes[f][b]);
    expLenQ.push_back(16'(outLen[f]));
    expCrcQ.push_back(crcBad[f]);
    expLongQ.push_back(tooLong[f]);
    framesSent++;
  endtask

  task automatic sendFrame(input int f);
    for (int g = 0; g < gapLen[f]; g++)
    begin
      driveNibble(1'b0, 4'h0);
      if (g == 0 && f > 0)
        firstDone = 1'b1;
      if (g == 1)
      begin
        MaxFL     = maxFlFor(f);         // Previous frame is out of the data states by now
        HugEn     = hugEnFor(f);
        IgnoreIfg = ignoreIfgFor(f);
      end
    end
    repeat (15)
      driveNibble(1'b1, PreambleNibble);
    driveNibble(1'b1, SfdNibble);
    if (accepted[f])
      queueFrame(f);
    for (int b = 0; b < frameLen[f]; b++)
    begin
      driveNibble(1'b1, frameBytes[f][b][3:0]);
      driveNibble(1'b1, frameBytes[f][b][7:4]);
    end
  endtask

  task automatic takeByte();
    logic [7:0] expData;
    int         expLen;
    if (expLenQ.size() == 0)
    begin
      $display("Extra byte 0x%0h reached the host at %0d ns with no frame expected",
               HostData, $time);
      errors++;
    end
    else
    begin
      expData = expByteQ.pop_front();
      expLen  = int'(expLenQ[0]);
      if (HostData !== expData)
        reportMismatch("HostData", expData, HostData);
      if (HostFirst !== (byteIdx == 0))
        reportMismatch("HostFirst", byteIdx == 0, HostFirst);
      if (HostLast !== (byteIdx == expLen - 1))
        reportMismatch("HostLast", byteIdx == expLen - 1, HostLast);
      if (HostLength !== expLenQ[0])
        reportMismatch("HostLength", expLenQ[0], HostLength);
      if (HostCrcErr !== expCrcQ[0])
        reportMismatch("HostCrcErr", expCrcQ[0], HostCrcErr);
      if (HostTooLong !== expLongQ[0])
        reportMismatch("HostTooLong", expLongQ[0], HostTooLong);
      byteIdx++;
      if (byteIdx == expLen)
      begin
        byteIdx = 0;
        void'(expLenQ.pop_front());
        void'(expCrcQ.pop_front());
        void'(expLongQ.pop_front());
        framesDone++;
      end
    end
  endtask

  // A host byte moves at the rising edge where HostValid is high and HostStall low
  always @(negedge MRxClk)
  begin
    if (monitorOn)
    begin
      if (prevStall && hostSnapshot() !== holdOut)
        reportMismatch("host outputs while stalled", holdOut, hostSnapshot());
      if (HostValid && !firstDone)
      begin
        $display("HostValid went high at %0d ns before the first frame ended on MII", $time);
        errors++;
      end
      nextStall = $urandom_range(3) == 0;
      if (HostValid && !nextStall)
        takeByte();
      prevStall = nextStall;
      holdOut   = hostSnapshot();
      HostStall = nextStall;
    end
  end

  initial
  begin
    wait (watchCycles > 0);
    repeat (watchCycles) @(posedge MRxClk);
    $display("Timeout after %0d cycles with %0d errors and %0d frames still expected",
             watchCycles, errors, expLenQ.size());
    $display("Something failed");
    $finish;
  end

  initial
  begin
    int quiet;
    void'($urandom(32'hbd4a));
    Reset     = 1'b1;
    MRxDV     = 1'b0;
    MRxD      = 4'h0;
    MaxFL     = maxFlFor(0);
    HugEn     = 1'b0;
    IgnoreIfg = 1'b0;
    HostStall = 1'b0;
    planFrames();
    repeat (2) @(posedge MRxClk);
    @(negedge MRxClk);
    Reset = 1'b0;
    @(posedge MRxClk);
    monitorOn = 1'b1;
    for (int f = 0; f < NumFrames; f++)
      sendFrame(f);
    driveNibble(1'b0, 4'h0);
    firstDone = 1'b1;
    quiet     = 0;
    while (expLenQ.size() > 0 && quiet < 1000)
    begin
      @(negedge MRxClk);
      quiet = HostValid ? 0 : quiet + 1;
    end
    if (expLenQ.size() > 0)
    begin
      $display("%0d expected frames never reached the host", expLenQ.size());
      errors += expLenQ.size();
    end
    repeat (100) @(negedge MRxClk);    // Room for any extra frame to show up
    $display("Closing: %0d errors, %0d of %0d frames delivered", errors, framesDone, framesSent);
    if (errors == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

// ==== sources.f ====
verilog/ethMiiPkg.sv
verilog/ethBufPkg.sv
verilog/ethRxStateM.sv
verilog/ethRxCounters.sv
verilog/ethRxCrc.sv
verilog/ethRxByteAssembler.sv
verilog/ethRxFifo.sv
verilog/ethRxHostReader.sv
verilog/ethRx.sv
testbench/ethRxTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps -Wno-fatal \
  --top-module ethRxTb -f sources.f -o ethRxTbSim

out=$(./obj_dir/ethRxTbSim)
echo "$out"

if echo "$out" | grep -qx "Everything OK"; then
  exit 0
fi
exit 1
